// File: hw/mips_pkg.sv
package mips_pkg;

    // first fetch address after reset
    localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;

    // destination of jal
    localparam logic [4:0] LINK_REG = 5'd31;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL   = 6'b000000;
    localparam logic [5:0] FN_SRL   = 6'b000010;
    localparam logic [5:0] FN_SRA   = 6'b000011;
    localparam logic [5:0] FN_JR    = 6'b001000;
    localparam logic [5:0] FN_JALR  = 6'b001001;
    localparam logic [5:0] FN_MFHI  = 6'b010000;
    localparam logic [5:0] FN_MFLO  = 6'b010010;
    localparam logic [5:0] FN_MULT  = 6'b011000;
    localparam logic [5:0] FN_MULTU = 6'b011001;
    localparam logic [5:0] FN_ADDU  = 6'b100001;
    localparam logic [5:0] FN_SUBU  = 6'b100011;
    localparam logic [5:0] FN_AND   = 6'b100100;
    localparam logic [5:0] FN_OR    = 6'b100101;
    localparam logic [5:0] FN_XOR   = 6'b100110;
    localparam logic [5:0] FN_SLT   = 6'b101010;
    localparam logic [5:0] FN_SLTU  = 6'b101011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // register write-back source
    typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_HI, WB_LO, WB_LINK} wb_sel_t;

    typedef enum logic [1:0] {DST_RT, DST_RD, DST_LINK} dst_sel_t;

    // kind of next address
    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JIMM, PC_JREG} pc_sel_t;

endpackage

// File: hw/mips_ctrl_if.sv
`timescale 1ns/100ps

interface mips_ctrl_if import mips_pkg::*; ();

    // alu controls
    alu_op_t  alu_op;
    logic     alu_src_imm;
    logic     imm_zero_ext;
    logic     shift_imm;

    // write-back controls
    logic     reg_write;
    dst_sel_t dst_sel;
    wb_sel_t  wb_sel;

    logic     mem_read;
    logic     mem_write;

    logic     hilo_write;
    logic     mul_signed;

    // next address kind and branch sense
    pc_sel_t  pc_sel;
    logic     branch_ne;

    modport decoder (
        output alu_op, alu_src_imm, imm_zero_ext, shift_imm,
        output reg_write, dst_sel, wb_sel,
        output mem_read, mem_write,
        output hilo_write, mul_signed,
        output pc_sel, branch_ne
    );

    modport alu (input alu_op, alu_src_imm, imm_zero_ext, shift_imm, branch_ne);

    modport regs (input reg_write, dst_sel, wb_sel);

    modport hilo (input hilo_write, mul_signed);

endinterface

// File: hw/mips_decoder.sv
`timescale 1ns/100ps

module mips_decoder import mips_pkg::*; (
    input  logic [31:0]         instr,
    input  logic                exec,
    input  logic                active,
    mips_ctrl_if.decoder        ctrl,
    output logic                data_read
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       reg_write_d;
    logic       mem_write_d;
    logic       hilo_write_d;
    logic       commit;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl.alu_op       = ALU_ADD;
        ctrl.alu_src_imm  = 1'b0;
        ctrl.imm_zero_ext = 1'b0;
        ctrl.shift_imm    = 1'b0;
        ctrl.dst_sel      = DST_RD;
        ctrl.wb_sel       = WB_ALU;
        ctrl.mem_read     = 1'b0;
        ctrl.mul_signed   = 1'b0;
        ctrl.pc_sel       = PC_SEQ;
        ctrl.branch_ne    = 1'b0;
        reg_write_d       = 1'b0;
        mem_write_d       = 1'b0;
        hilo_write_d      = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                // r-type writes rd unless told otherwise below
                reg_write_d = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        ctrl.shift_imm = 1'b1;
                        if (funct == FN_SLL) begin
                            ctrl.alu_op = ALU_SLL;
                        end else if (funct == FN_SRL) begin
                            ctrl.alu_op = ALU_SRL;
                        end else begin
                            ctrl.alu_op = ALU_SRA;
                        end
                    end
                    FN_JR: begin
                        ctrl.pc_sel = PC_JREG;
                        reg_write_d = 1'b0;
                    end
                    FN_JALR: begin
                        ctrl.pc_sel = PC_JREG;
                        ctrl.wb_sel = WB_LINK;
                    end
                    FN_MFHI: ctrl.wb_sel = WB_HI;
                    FN_MFLO: ctrl.wb_sel = WB_LO;
                    // multiplies only touch hi/lo
                    FN_MULT, FN_MULTU: begin
                        reg_write_d     = 1'b0;
                        hilo_write_d    = 1'b1;
                        ctrl.mul_signed = (funct == FN_MULT);
                    end
                    default: reg_write_d = 1'b0;
                endcase
            end
            OP_J:   ctrl.pc_sel = PC_JIMM;
            OP_JAL: begin
                ctrl.pc_sel  = PC_JIMM;
                ctrl.dst_sel = DST_LINK;
                ctrl.wb_sel  = WB_LINK;
                reg_write_d  = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.pc_sel    = PC_BRANCH;
                ctrl.branch_ne = (opcode == OP_BNE);
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.alu_src_imm  = 1'b1;
                ctrl.imm_zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                                    (opcode == OP_XORI);
                ctrl.dst_sel      = DST_RT;
                reg_write_d       = 1'b1;
                case (opcode)
                    OP_SLTI: ctrl.alu_op = ALU_SLT;
                    OP_ANDI: ctrl.alu_op = ALU_AND;
                    OP_ORI:  ctrl.alu_op = ALU_OR;
                    OP_XORI: ctrl.alu_op = ALU_XOR;
                    OP_LUI:  ctrl.alu_op = ALU_LUI;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                ctrl.mem_read = 1'b1;
                ctrl.dst_sel  = DST_RT;
                ctrl.wb_sel   = WB_MEM;
                reg_write_d   = 1'b1;
            end
            OP_SW:   mem_write_d = 1'b1;
            default: ctrl.pc_sel = PC_SEQ;
        endcase
    end

    // state only changes at the end of the execute phase
    assign commit          = exec && active;
    assign ctrl.reg_write  = reg_write_d && commit;
    assign ctrl.mem_write  = mem_write_d && commit;
    assign ctrl.hilo_write = hilo_write_d && commit;

    assign data_read = ctrl.mem_read;

endmodule

// File: hw/mips_pc.sv
`timescale 1ns/100ps

module mips_pc import mips_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                clk_enable,
    input  logic [31:0]         instr,
    input  logic [31:0]         rs_data,
    input  logic                branch_taken,
    mips_ctrl_if.decoder        ctrl,
    output logic [31:0]         pc,
    output logic [31:0]         delay_slot,
    output logic                exec,
    output logic                active
);

    logic [31:0] branch_off;
    logic [31:0] next_addr;

    assign branch_off = {{14{instr[15]}}, instr[15:0], 2'b00};

    // target of the instruction after the delay slot
    always_comb begin
        case (ctrl.pc_sel)
            PC_BRANCH: begin
                if (branch_taken) begin
                    next_addr = delay_slot + branch_off;
                end else begin
                    next_addr = delay_slot + 32'd4;
                end
            end
            PC_JIMM: next_addr = {delay_slot[31:28], instr[25:0], 2'b00};
            PC_JREG: next_addr = rs_data;
            default: next_addr = delay_slot + 32'd4;
        endcase
    end

    // halted once pc reaches address 0
    assign active = (pc != 32'd0);

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                pc         <= RESET_VECTOR;
                delay_slot <= RESET_VECTOR + 32'd4;
                exec       <= 1'b0;
            end else if (active) begin
                if (!exec) begin
                    exec <= 1'b1;
                end else begin
                    exec       <= 1'b0;
                    pc         <= delay_slot;
                    delay_slot <= next_addr;
                end
            end
        end
    end

endmodule

// File: hw/mips_regfile.sv
`timescale 1ns/100ps

module mips_regfile import mips_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                clk_enable,
    input  logic [31:0]         instr,
    mips_ctrl_if.regs           ctrl,
    input  logic [31:0]         alu_result,
    input  logic [31:0]         mem_data,
    input  logic [31:0]         hi,
    input  logic [31:0]         lo,
    input  logic [31:0]         delay_slot,
    output logic [31:0]         rs_data,
    output logic [31:0]         rt_data,
    output logic [31:0]         register_v0
);

    logic [31:0] regs [0:31];
    logic [4:0]  rs_idx;
    logic [4:0]  rt_idx;
    logic [4:0]  dst_idx;
    logic [31:0] wb_data;

    assign rs_idx = instr[25:21];
    assign rt_idx = instr[20:16];

    // $0 is hardwired to zero
    assign rs_data     = (rs_idx == 5'd0) ? 32'd0 : regs[rs_idx];
    assign rt_data     = (rt_idx == 5'd0) ? 32'd0 : regs[rt_idx];
    assign register_v0 = regs[2];

    always_comb begin
        case (ctrl.dst_sel)
            DST_RT:   dst_idx = rt_idx;
            DST_LINK: dst_idx = LINK_REG;
            default:  dst_idx = instr[15:11];
        endcase
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = mem_data;
            WB_HI:   wb_data = hi;
            WB_LO:   wb_data = lo;
            // return address skips the delay slot
            WB_LINK: wb_data = delay_slot + 32'd4;
            default: wb_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (clk_enable && ctrl.reg_write && (dst_idx != 5'd0)) begin
            regs[dst_idx] <= wb_data;
        end
    end

endmodule

// File: hw/mips_alu.sv
`timescale 1ns/100ps

module mips_alu import mips_pkg::*; (
    input  logic [31:0]         instr,
    input  logic [31:0]         rs_data,
    input  logic [31:0]         rt_data,
    mips_ctrl_if.alu            ctrl,
    output logic [31:0]         result,
    output logic [31:0]         mem_addr,
    output logic                branch_taken
);

    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] op_b;
    logic [4:0]  shamt;

    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'd0, instr[15:0]};

    // second operand from the immediate or rt
    always_comb begin
        if (!ctrl.alu_src_imm) begin
            op_b = rt_data;
        end else if (ctrl.imm_zero_ext) begin
            op_b = imm_zext;
        end else begin
            op_b = imm_sext;
        end
    end

    // shift amount from the shamt field or the low bits of rs
    assign shamt = ctrl.shift_imm ? instr[10:6] : rs_data[4:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:  result = rs_data - op_b;
            ALU_AND:  result = rs_data & op_b;
            ALU_OR:   result = rs_data | op_b;
            ALU_XOR:  result = rs_data ^ op_b;
            ALU_SLT: begin
                result = {31'd0, $signed(rs_data) < $signed(op_b)};
            end
            ALU_SLTU: begin
                result = {31'd0, rs_data < op_b};
            end
            // shifts operate on rt
            ALU_SLL:  result = op_b << shamt;
            ALU_SRL:  result = op_b >> shamt;
            ALU_SRA:  result = $signed(op_b) >>> shamt;
            ALU_LUI:  result = {instr[15:0], 16'd0};
            default:  result = rs_data + op_b;
        endcase
    end

    // lw/sw effective address
    assign mem_addr = rs_data + imm_sext;

    // beq condition inverted for bne
    assign branch_taken = (rs_data == rt_data) ^ ctrl.branch_ne;

endmodule

// File: hw/mips_hilo.sv
`timescale 1ns/100ps

module mips_hilo (
    input  logic                clk,
    input  logic                reset,
    input  logic                clk_enable,
    input  logic [31:0]         rs_data,
    input  logic [31:0]         rt_data,
    mips_ctrl_if.hilo           ctrl,
    output logic [31:0]         hi,
    output logic [31:0]         lo
);

    logic [63:0] prod_signed;
    logic [63:0] prod_unsigned;
    logic [63:0] product;

    // operands widen to 64 bits before the multiply
    assign prod_signed   = $signed(rs_data) * $signed(rt_data);
    assign prod_unsigned = {32'd0, rs_data} * {32'd0, rt_data};
    assign product       = ctrl.mul_signed ? prod_signed : prod_unsigned;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= 32'd0;
            lo <= 32'd0;
        end else if (clk_enable && ctrl.hilo_write) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

endmodule

// File: hw/mips_cpu_harvard.sv
`timescale 1ns/100ps

module mips_cpu_harvard (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    output logic        active,
    output logic [31:0] register_v0,

    // instruction port with combinational read
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    // data port
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    logic [31:0] pc;
    logic [31:0] delay_slot;
    logic        exec;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_result;
    logic [31:0] mem_addr;
    logic        branch_taken;
    logic [31:0] hi;
    logic [31:0] lo;

    mips_ctrl_if ctrl_if ();

    mips_decoder decoder_i (
        .instr      (instr_readdata),
        .exec       (exec),
        .active     (active),
        .ctrl       (ctrl_if),
        .data_read  (data_read)
    );

    mips_pc pc_i (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .instr        (instr_readdata),
        .rs_data      (rs_data),
        .branch_taken (branch_taken),
        .ctrl         (ctrl_if),
        .pc           (pc),
        .delay_slot   (delay_slot),
        .exec         (exec),
        .active       (active)
    );

    mips_regfile regfile_i (
        .clk         (clk),
        .reset       (reset),
        .clk_enable  (clk_enable),
        .instr       (instr_readdata),
        .ctrl        (ctrl_if),
        .alu_result  (alu_result),
        .mem_data    (data_readdata),
        .hi          (hi),
        .lo          (lo),
        .delay_slot  (delay_slot),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    mips_alu alu_i (
        .instr        (instr_readdata),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .ctrl         (ctrl_if),
        .result       (alu_result),
        .mem_addr     (mem_addr),
        .branch_taken (branch_taken)
    );

    mips_hilo hilo_i (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .ctrl       (ctrl_if),
        .hi         (hi),
        .lo         (lo)
    );

    assign instr_address  = pc;
    assign data_address   = mem_addr;
    assign data_writedata = rt_data;
    assign data_write     = ctrl_if.mem_write;

endmodule

// File: tests/mips_cpu_chk.sv
`timescale 1ns/100ps

module mips_cpu_chk (
    input logic        clk,
    input logic        reset,
    input logic        clk_enable,
    input logic        active,
    input logic        data_write,
    input logic        data_read,
    input logic [31:0] instr_address
);

    // a halted cpu must not store
    write_needs_active: assert property (
        @(posedge clk) disable iff (reset) data_write |-> active
    ) else $error("data_write while inactive");

    read_write_excl: assert property (
        @(posedge clk) disable iff (reset) !(data_write && data_read)
    ) else $error("data_write and data_read together");

    fetch_aligned: assert property (
        @(posedge clk) disable iff (reset) instr_address[1:0] == 2'b00
    ) else $error("unaligned instr_address");

    // reset vector is nonzero so the cpu comes up running
    active_after_reset: assert property (
        @(posedge clk) (reset && clk_enable) |=> active
    ) else $error("active low after reset");

endmodule

// File: tests/mips_tb.sv
`timescale 1ns/100ps

module mips_tb import mips_pkg::*; ();

    localparam int TIMEOUT = 5000;

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:255];
    logic [31:0] imem_off;
    logic [31:0] prog [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic        gaps_on;

    mips_cpu_harvard dut_i (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    bind mips_cpu_harvard mips_cpu_chk chk_i (
        .clk           (clk),
        .reset         (reset),
        .clk_enable    (clk_enable),
        .active        (active),
        .data_write    (data_write),
        .data_read     (data_read),
        .instr_address (instr_address)
    );

    always #5 clk = ~clk;

    // program image starts at the reset vector and anything else reads as nop
    assign imem_off       = (instr_address - RESET_VECTOR) >> 2;
    assign instr_readdata = (imem_off < 32'd64) ? imem[imem_off[5:0]] : 32'd0;
    // read data only while the cpu asks for it
    assign data_readdata  = data_read ? dmem[data_address[9:2]] : 32'd0;

    always @(posedge clk) begin
        if (data_write && clk_enable && !reset) begin
            dmem[data_address[9:2]] <= data_writedata;
            got_addr.push_back(data_address);
            got_data.push_back(data_writedata);
        end
    end

    // random stall gaps when enabled
    always @(posedge clk) begin
        clk_enable <= reset || !gaps_on || (($urandom % 4) != 0);
    end

    function automatic logic [31:0] fill_word(input int i);
        return 32'h9E37_79B9 * (i + 1);
    endfunction

    function automatic logic [15:0] rand16();
        logic [31:0] t;
        t = $urandom;
        return t[15:0];
    endfunction

    function automatic logic [4:0] pick_reg();
        case ($urandom % 6)
            0: return 5'd2;
            1: return 5'd8;
            2: return 5'd9;
            3: return 5'd10;
            4: return 5'd11;
            default: return 5'd12;
        endcase
    endfunction

    function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype(input logic [5:0] op, input int idx);
        logic [31:0] target;
        target = RESET_VECTOR + 32'(idx * 4);
        return {op, target[27:2]};
    endfunction

    // ISA model of the whole program that also queues the expected stores
    function automatic logic [31:0] mips_ref();
        logic [31:0] r [0:31];
        logic [31:0] dm [0:255];
        logic [31:0] hi, lo, pc, ds, nxt, ins, a, b, se, ea, wv, off;
        logic [63:0] p;
        logic [4:0]  rs, rt, dst;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            r[i] = 32'd0;
        end
        for (int i = 0; i < 256; i++) begin
            dm[i] = fill_word(i);
        end
        hi = 32'd0;
        lo = 32'd0;
        pc = RESET_VECTOR;
        ds = RESET_VECTOR + 32'd4;
        steps = 0;
        while (pc != 32'd0 && steps < 2000) begin
            off = (pc - RESET_VECTOR) >> 2;
            ins = (off < 32'd64) ? imem[off[5:0]] : 32'd0;
            rs  = ins[25:21];
            rt  = ins[20:16];
            a   = r[rs];
            b   = r[rt];
            se  = {{16{ins[15]}}, ins[15:0]};
            ea  = a + se;
            nxt = ds + 32'd4;
            wr  = 1'b1;
            dst = rt;
            wv  = 32'd0;
            case (ins[31:26])
                OP_SPECIAL: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        FN_ADDU:  wv = a + b;
                        FN_SUBU:  wv = a - b;
                        FN_AND:   wv = a & b;
                        FN_OR:    wv = a | b;
                        FN_XOR:   wv = a ^ b;
                        FN_SLT:   wv = {31'd0, $signed(a) < $signed(b)};
                        FN_SLTU:  wv = {31'd0, a < b};
                        FN_SLL:   wv = b << ins[10:6];
                        FN_SRL:   wv = b >> ins[10:6];
                        FN_SRA:   wv = $signed(b) >>> ins[10:6];
                        FN_MFHI:  wv = hi;
                        FN_MFLO:  wv = lo;
                        FN_JALR: begin
                            nxt = a;
                            wv  = ds + 32'd4;
                        end
                        FN_JR: begin
                            nxt = a;
                            wr  = 1'b0;
                        end
                        FN_MULT, FN_MULTU: begin
                            if (ins[5:0] == FN_MULT) begin
                                p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                            end else begin
                                p = {32'd0, a} * {32'd0, b};
                            end
                            hi = p[63:32];
                            lo = p[31:0];
                            wr = 1'b0;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                OP_J, OP_JAL: begin
                    nxt = {ds[31:28], ins[25:0], 2'b00};
                    dst = 5'd31;
                    wv  = ds + 32'd4;
                    wr  = (ins[31:26] == OP_JAL);
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) != (ins[31:26] == OP_BNE)) begin
                        nxt = ds + (se << 2);
                    end
                end
                OP_ADDIU: wv = a + se;
                OP_SLTI:  wv = {31'd0, $signed(a) < $signed(se)};
                OP_ANDI:  wv = a & {16'd0, ins[15:0]};
                OP_ORI:   wv = a | {16'd0, ins[15:0]};
                OP_XORI:  wv = a ^ {16'd0, ins[15:0]};
                OP_LUI:   wv = {ins[15:0], 16'd0};
                OP_LW:    wv = dm[ea[9:2]];
                OP_SW: begin
                    wr = 1'b0;
                    dm[ea[9:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                r[dst] = wv;
            end
            pc = ds;
            ds = nxt;
            steps++;
        end
        return r[2];
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timed_out(input string what);
        $display("timed out waiting for %s at %0t", what, $time);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic apply_reset();
        gaps_on <= 1'b0;
        @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic run_program(input logic gaps, input string name);
        logic [31:0] v0_exp;
        int          n;
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'd0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= fill_word(i);
        end
        exp_addr.delete();
        exp_data.delete();
        v0_exp = mips_ref();
        apply_reset();
        got_addr.delete();
        got_data.delete();
        gaps_on <= gaps;
        for (int k = 0; k < exp_addr.size(); k++) begin
            n = 0;
            while (got_addr.size() <= k) begin
                @(negedge clk);
                n++;
                if (n > TIMEOUT) begin
                    timed_out({name, " store"});
                end
            end
            check(got_addr[k], exp_addr[k], {name, " store address"});
            check(got_data[k], exp_data[k], {name, " store data"});
        end
        n = 0;
        while (active !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                timed_out({name, " halt"});
            end
        end
        check(32'(got_addr.size()), 32'(exp_addr.size()), {name, " store count"});
        check(register_v0, v0_exp, {name, " v0"});
        check(instr_address, 32'd0, {name, " halt address"});
        gaps_on <= 1'b0;
    endtask

    task automatic build_alu();
        logic [5:0] fns [0:9];
        logic [5:0] ops [0:5];
        logic [4:0] dst;
        int         sel;
        fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL,
                FN_SRA};
        ops = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI};
        prog.delete();
        for (int i = 8; i <= 12; i++) begin
            emit(itype(OP_LUI, 5'(i), 5'd0, rand16()));
            emit(itype(OP_ORI, 5'(i), 5'(i), rand16()));
        end
        for (int i = 0; i < 24; i++) begin
            // last op always lands in v0
            dst = (i == 23) ? 5'd2 : pick_reg();
            sel = $urandom % 16;
            if (sel < 10) begin
                emit(rtype(fns[sel], dst, pick_reg(), pick_reg(), 5'($urandom % 32)));
            end else begin
                emit(itype(ops[sel - 10], dst, pick_reg(), rand16()));
            end
        end
        emit(rtype(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
        emit(32'd0);
    endtask

    task automatic build_mem();
        prog.delete();
        emit(itype(OP_ADDIU, 5'd8, 5'd0, 16'h0040));
        for (int k = 0; k < 4; k++) begin
            emit(itype(OP_LUI, 5'd9, 5'd0, rand16()));
            emit(itype(OP_ORI, 5'd9, 5'd9, rand16()));
            emit(itype(OP_SW, 5'd9, 5'd8, 16'(k * 4)));
        end
        emit(itype(OP_LW, 5'd10, 5'd8, 16'h0008));
        emit(itype(OP_SW, 5'd10, 5'd8, 16'h0020));
        emit(itype(OP_LW, 5'd11, 5'd0, 16'h0010));
        emit(itype(OP_SW, 5'd11, 5'd8, 16'h0024));
        emit(itype(OP_LW, 5'd2, 5'd8, 16'h0004));
        emit(rtype(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
        emit(32'd0);
    endtask

    task automatic build_branch();
        prog.delete();
        emit(itype(OP_ADDIU, 5'd8, 5'd0, 16'd5));
        emit(itype(OP_BEQ, 5'd8, 5'd8, 16'd2));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd1));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd100));
        emit(itype(OP_BNE, 5'd8, 5'd8, 16'd5));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd2));
        emit(jtype(OP_JAL, 9));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd4));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd1000));
        emit(rtype(FN_ADDU, 5'd2, 5'd2, 5'd31, 5'd0));
        emit(jtype(OP_J, 13));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd8));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd2000));
        emit(itype(OP_LUI, 5'd9, 5'd0, RESET_VECTOR[31:16]));
        emit(itype(OP_ORI, 5'd9, 5'd9, 16'(17 * 4)));
        emit(rtype(FN_JALR, 5'd10, 5'd9, 5'd0, 5'd0));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd16));
        emit(rtype(FN_ADDU, 5'd2, 5'd2, 5'd10, 5'd0));
        // unequal operands, beq falls through and bne is taken
        emit(itype(OP_BEQ, 5'd0, 5'd8, 16'd2));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd32));
        emit(itype(OP_BNE, 5'd0, 5'd8, 16'd2));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd64));
        emit(itype(OP_ADDIU, 5'd2, 5'd2, 16'd3000));
        emit(rtype(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
        emit(32'd0);
    endtask

    task automatic build_mult();
        prog.delete();
        emit(itype(OP_LUI, 5'd8, 5'd0, rand16()));
        emit(itype(OP_ORI, 5'd8, 5'd8, rand16()));
        emit(itype(OP_LUI, 5'd9, 5'd0, rand16()));
        emit(itype(OP_ORI, 5'd9, 5'd9, rand16()));
        emit(rtype(FN_MULT, 5'd0, 5'd8, 5'd9, 5'd0));
        emit(rtype(FN_MFHI, 5'd10, 5'd0, 5'd0, 5'd0));
        emit(rtype(FN_MFLO, 5'd11, 5'd0, 5'd0, 5'd0));
        emit(itype(OP_SW, 5'd10, 5'd0, 16'd0));
        emit(itype(OP_SW, 5'd11, 5'd0, 16'd4));
        emit(rtype(FN_MULTU, 5'd0, 5'd8, 5'd9, 5'd0));
        emit(rtype(FN_MFHI, 5'd12, 5'd0, 5'd0, 5'd0));
        emit(itype(OP_SW, 5'd12, 5'd0, 16'd8));
        emit(rtype(FN_MFLO, 5'd2, 5'd0, 5'd0, 5'd0));
        emit(rtype(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
        emit(32'd0);
    endtask

    initial begin
        void'($urandom(40));
        clk        = 1'b0;
        reset      = 1'b1;
        clk_enable = 1'b1;
        gaps_on    = 1'b0;
        for (int i = 0; i < 3; i++) begin
            build_alu();
            run_program(1'b0, "alu");
        end
        build_mem();
        run_program(1'b0, "load/store");
        run_program(1'b1, "load/store with gaps");
        build_branch();
        run_program(1'b0, "branch");
        run_program(1'b1, "branch with gaps");
        for (int i = 0; i < 3; i++) begin
            build_mult();
            run_program(1'b0, "mult");
        end
        // halted state stays frozen until a reset restarts it
        repeat (10) @(negedge clk);
        check(instr_address, 32'd0, "frozen halt address");
        check({31'd0, active}, 32'd0, "frozen active");
        @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check(register_v0, 32'd0, "v0 after reset");
        check(instr_address, RESET_VECTOR, "fetch address after reset");
        check({31'd0, active}, 32'd1, "active after reset");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verilog.f
hw/mips_pkg.sv
hw/mips_ctrl_if.sv
hw/mips_decoder.sv
hw/mips_pc.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_hilo.sv
hw/mips_cpu_harvard.sv
tests/mips_cpu_chk.sv
tests/mips_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mips_tb
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)
